// File: include/pn_config.svh
`ifndef PN_CONFIG_SVH
`define PN_CONFIG_SVH

// ===========================================================================
// Frame storage
// ===========================================================================

// Buffer slots; a frame carries at most 15 tokens
`define PN_MAX_TOKENS 16
// Token index and token count width
`define PN_TOKEN_IDX_W 4

// ===========================================================================
// Operand stack and arithmetic
// ===========================================================================

// Deep enough for any well-formed 15 token frame
`define PN_STACK_DEPTH 8
`define PN_STACK_PTR_W 4
`define PN_DATA_W 32

`endif

// File: design/pn_pkg.sv
`include "pn_config.svh"

package pn_pkg;

    // Signed arithmetic word carried by the stack and the ALU
    typedef logic signed [`PN_DATA_W-1:0] pn_data_t;

    typedef logic [`PN_TOKEN_IDX_W-1:0] pn_tok_idx_t;

    // Operator codes; 4 to 7 are undefined and fall back to add
    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_SUB     = 3'd1,
        OP_MUL     = 3'd2,
        OP_ABS_SUM = 3'd3
    } pn_op_e;

    // Scan order of a frame
    typedef enum logic {
        MODE_PREFIX  = 1'b0,
        MODE_POSTFIX = 1'b1
    } pn_mode_e;

    // Operand view of a stored token
    typedef struct packed {
        logic       is_operator;
        logic [2:0] value;
    } pn_operand_view_t;

    // Operator view, flag in the same top bit
    typedef struct packed {
        logic   is_operator;
        pn_op_e code;
    } pn_operator_view_t;

    // One 4-bit token word, decoded either way
    typedef union packed {
        pn_operand_view_t  operand;
        pn_operator_view_t oper;
    } pn_token_u;

endpackage

// File: design/pn_token_if.sv
`timescale 1ns/1ps

// Link between the token buffer and the evaluator
interface pn_token_if;
    import pn_pkg::*;

    // Read index, owned by the evaluator
    pn_tok_idx_t rd_idx;

    // Frame contents and status, owned by the buffer
    pn_token_u   token;
    pn_tok_idx_t token_count;
    pn_mode_e    frame_mode;
    logic        frame_done;

    modport buffer (
        input  rd_idx,
        output token, token_count, frame_mode, frame_done
    );

    modport evaluator (
        output rd_idx,
        input  token, token_count, frame_mode, frame_done
    );

endinterface

// File: design/pn_stack_if.sv
`timescale 1ns/1ps

// Link between the evaluator and the operand stack
interface pn_stack_if;
    import pn_pkg::*;

    // Stack commands, never push and pop in the same cycle
    logic     push;
    logic     pop;
    pn_data_t push_data;

    // Current top entry
    pn_data_t top;

    modport stack (
        input  push, pop, push_data,
        output top
    );

    modport evaluator (
        output push, pop, push_data,
        input  top
    );

endinterface

// File: design/pn_alu.sv
`timescale 1ns/1ps

module pn_alu (
    input  pn_pkg::pn_data_t lhs,
    input  pn_pkg::pn_data_t rhs,
    input  pn_pkg::pn_op_e   op,
    output pn_pkg::pn_data_t result
);
    import pn_pkg::*;

    pn_data_t sum;

    // Shared by add and the absolute sum
    assign sum = lhs + rhs;

    always_comb begin
        case (op)
            OP_ADD: begin
                result = sum;
            end
            OP_SUB: begin
                result = lhs - rhs;
            end
            OP_MUL: begin
                // Low word of the product, wraps like the other ops
                result = lhs * rhs;
            end
            OP_ABS_SUM: begin
                result = (sum < 0) ? -sum : sum;
            end
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

// File: design/pn_operand_stack.sv
`timescale 1ns/1ps
`include "pn_config.svh"

module pn_operand_stack (
    input  logic      clk,
    input  logic      rst_n,
    pn_stack_if.stack stk
);
    import pn_pkg::*;

    localparam int ADDR_W = $clog2(`PN_STACK_DEPTH);

    pn_data_t                   entries [`PN_STACK_DEPTH];
    logic [`PN_STACK_PTR_W-1:0] ptr;
    logic [ADDR_W-1:0]          wr_addr;
    logic [ADDR_W-1:0]          top_addr;

    // Pointer names the next free slot
    assign wr_addr  = ptr[ADDR_W-1:0];
    assign top_addr = wr_addr - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (stk.push) begin
            ptr <= ptr + 1'b1;
        end else if (stk.pop) begin
            ptr <= ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stk.push) begin
            entries[wr_addr] <= stk.push_data;
        end
    end

    // No guard on empty; well-formed frames never read below the base
    assign stk.top = entries[top_addr];

endmodule

// File: design/pn_token_buffer.sv
`timescale 1ns/1ps
`include "pn_config.svh"

module pn_token_buffer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       mode,
    input  logic       operator,
    input  logic [2:0] in,
    pn_token_if.buffer tok
);
    import pn_pkg::*;

    pn_token_u   entries [`PN_MAX_TOKENS];
    pn_token_u   new_tok;
    pn_tok_idx_t count_q;
    pn_tok_idx_t wr_idx;
    pn_mode_e    mode_q;
    logic        in_valid_q;
    logic        frame_start;

    // ===========================================================================
    // Frame boundaries
    // ===========================================================================

    // First token of a frame restarts the write index at zero
    assign frame_start = in_valid && !in_valid_q;
    assign wr_idx      = frame_start ? '0 : count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
            count_q    <= '0;
            mode_q     <= MODE_PREFIX;
        end else begin
            in_valid_q <= in_valid;
            if (in_valid) begin
                count_q <= wr_idx + pn_tok_idx_t'(1);
            end
            // Mode is only meaningful alongside the first token
            if (frame_start) begin
                mode_q <= pn_mode_e'(mode);
            end
        end
    end

    // ===========================================================================
    // Token storage
    // ===========================================================================

    // Pack the flag and 3-bit field through the operand view
    always_comb begin
        new_tok.operand.is_operator = operator;
        new_tok.operand.value       = in;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            entries[wr_idx] <= new_tok;
        end
    end

    assign tok.token       = entries[tok.rd_idx];
    assign tok.token_count = count_q;
    assign tok.frame_mode  = mode_q;
    // Falling edge of in_valid closes the frame
    assign tok.frame_done  = in_valid_q && !in_valid;

endmodule

// File: design/pn_evaluator.sv
`timescale 1ns/1ps

module pn_evaluator (
    input  logic             clk,
    input  logic             rst_n,
    pn_token_if.evaluator    tok,
    output logic             out_valid,
    output pn_pkg::pn_data_t out
);
    import pn_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        POP_FIRST,
        POP_SECOND,
        CALC,
        FINISH
    } state_e;

    state_e      state;
    state_e      state_nxt;
    pn_tok_idx_t rd_idx;
    pn_tok_idx_t next_idx;
    pn_data_t    first_q;
    pn_data_t    second_q;
    pn_data_t    lhs;
    pn_data_t    rhs;
    pn_data_t    alu_result;
    logic        postfix;
    logic        last_tok;
    logic        is_oper;

    pn_stack_if stk_bus ();

    // ===========================================================================
    // Scan position
    // ===========================================================================

    assign postfix  = (tok.frame_mode == MODE_POSTFIX);
    assign is_oper  = tok.token.oper.is_operator;
    assign next_idx = postfix ? rd_idx + pn_tok_idx_t'(1) : rd_idx - pn_tok_idx_t'(1);

    // Postfix runs forward to count-1, prefix runs backward to zero
    assign last_tok = postfix ? (rd_idx == tok.token_count - pn_tok_idx_t'(1))
                              : (rd_idx == '0);

    assign tok.rd_idx = rd_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx <= '0;
        end else if (state == IDLE && tok.frame_done) begin
            rd_idx <= postfix ? '0 : tok.token_count - pn_tok_idx_t'(1);
        end else if ((state == DECODE && !is_oper) || state == CALC) begin
            rd_idx <= next_idx;
        end
    end

    // ===========================================================================
    // FSM
    // ===========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (tok.frame_done) begin
                    state_nxt = DECODE;
                end
            end
            DECODE: begin
                if (is_oper) begin
                    state_nxt = POP_FIRST;
                end else if (last_tok) begin
                    state_nxt = FINISH;
                end
            end
            POP_FIRST: begin
                state_nxt = POP_SECOND;
            end
            POP_SECOND: begin
                state_nxt = CALC;
            end
            CALC: begin
                state_nxt = last_tok ? FINISH : DECODE;
            end
            FINISH: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ===========================================================================
    // Stack and ALU datapath
    // ===========================================================================

    // Operands push in DECODE, operator results push in CALC
    assign stk_bus.push      = (state == DECODE && !is_oper) || state == CALC;
    assign stk_bus.pop       = state == POP_FIRST || state == POP_SECOND || state == FINISH;
    assign stk_bus.push_data = (state == CALC) ? alu_result
                                               : pn_data_t'(tok.token.operand.value);

    always_ff @(posedge clk) begin
        if (state == POP_FIRST) begin
            first_q <= stk_bus.top;
        end
        if (state == POP_SECOND) begin
            second_q <= stk_bus.top;
        end
    end

    // First pop is the right operand in postfix, the left one in prefix
    assign lhs = postfix ? second_q : first_q;
    assign rhs = postfix ? first_q  : second_q;

    pn_alu u_alu (
        .lhs    (lhs),
        .rhs    (rhs),
        .op     (tok.token.oper.code),
        .result (alu_result)
    );

    pn_operand_stack u_stack (
        .clk   (clk),
        .rst_n (rst_n),
        .stk   (stk_bus.stack)
    );

    // Final value leaves the stack as a single-cycle pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= (state == FINISH);
            out       <= (state == FINISH) ? stk_bus.top : '0;
        end
    end

endmodule

// File: design/pn_top.sv
`timescale 1ns/1ps

module pn_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             mode,
    input  logic             operator,
    input  logic [2:0]       in,
    output logic             out_valid,
    output pn_pkg::pn_data_t out
);

    // Frame contents and status between capture and evaluation
    pn_token_if tok_bus ();

    // ===========================================================================
    // Token capture
    // ===========================================================================

    pn_token_buffer u_token_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .mode     (mode),
        .operator (operator),
        .in       (in),
        .tok      (tok_bus.buffer)
    );

    // ===========================================================================
    // Scan and evaluate
    // ===========================================================================

    pn_evaluator u_evaluator (
        .clk       (clk),
        .rst_n     (rst_n),
        .tok       (tok_bus.evaluator),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

// File: dv/pn_tb.sv
`timescale 1ns/1ps
`include "pn_config.svh"

module pn_tb;
    import pn_pkg::*;

    // 40-odd frames of up to 15 input and 65 evaluation cycles, plus margin
    localparam int MAX_CYCLES = 6000;
    localparam int WAIT_LIMIT = 200;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             mode;
    logic             operator;
    logic [2:0]       in;
    logic             out_valid;
    pn_data_t         out;

    // Current frame, indexed in transmit order
    logic             tok_is_op [`PN_MAX_TOKENS];
    logic [2:0]       tok_val   [`PN_MAX_TOKENS];

    int               errors;
    int               pass_count;
    int               fail_count;
    int               cycles;
    logic             valid_prev;

    pn_top u_pn_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .operator  (operator),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: no finish after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic check_result(input pn_data_t actual, input pn_data_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: out expected %0d, got %0d", $time, expected, actual);
            errors++;
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: out_valid expected %b, got %b",
                     $time, expected, actual);
            errors++;
        end
    endtask

    // out stays zero outside the pulse, and the pulse is one cycle wide
    always @(negedge clk) begin
        if (rst_n) begin
            if (!out_valid) begin
                check_result(out, '0);
            end
            if (valid_prev) begin
                check_valid(out_valid, 1'b0);
            end
            valid_prev = out_valid;
        end
    end

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            pass_count++;
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
            fail_count++;
        end
    endtask

    // ========================================================================
    // Reference model and frame handling
    // ========================================================================

    task automatic eval_ref(input int n, input pn_mode_e m, output pn_data_t res);
        pn_data_t stack [`PN_MAX_TOKENS];
        pn_data_t first;
        pn_data_t second;
        pn_data_t lhs;
        pn_data_t rhs;
        pn_data_t sum;
        int       sp;
        int       i;
        sp = 0;
        for (int k = 0; k < n; k++) begin
            i = (m == MODE_POSTFIX) ? k : n - 1 - k;
            if (!tok_is_op[i]) begin
                stack[sp] = $signed({29'd0, tok_val[i]});
                sp++;
            end else begin
                first  = stack[sp-1];
                second = stack[sp-2];
                sp     = sp - 2;
                // Postfix pops the right operand first, prefix the left one
                lhs    = (m == MODE_POSTFIX) ? second : first;
                rhs    = (m == MODE_POSTFIX) ? first  : second;
                sum    = lhs + rhs;
                case (pn_op_e'(tok_val[i]))
                    OP_SUB:     stack[sp] = lhs - rhs;
                    OP_MUL:     stack[sp] = lhs * rhs;
                    OP_ABS_SUM: stack[sp] = (sum < 0) ? -sum : sum;
                    default:    stack[sp] = sum;
                endcase
                sp++;
            end
        end
        res = stack[0];
    endtask

    task automatic set_tok(input int idx, input logic is_op, input logic [2:0] val);
        tok_is_op[idx] = is_op;
        tok_val[idx]   = val;
    endtask

    task automatic send_frame(input int n, input pn_mode_e m);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            mode     <= (i == 0) ? m : 1'b0;
            operator <= tok_is_op[i];
            in       <= tok_val[i];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        operator <= 1'b0;
        in       <= '0;
    endtask

    task automatic wait_out_valid(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            if (out_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("ERROR at %0t: out_valid never arrived within %0d cycles",
                     $time, WAIT_LIMIT);
            errors++;
        end
    endtask

    // Returns at the negedge inside the out_valid cycle
    task automatic run_frame(input int n, input pn_mode_e m);
        pn_data_t expected;
        bit       seen;
        eval_ref(n, m, expected);
        send_frame(n, m);
        wait_out_valid(seen);
        if (seen) begin
            check_result(out, expected);
        end
    endtask

    task automatic run_binary(input pn_mode_e m, input pn_op_e op,
                              input logic [2:0] a, input logic [2:0] b);
        if (m == MODE_POSTFIX) begin
            set_tok(0, 1'b0, a);
            set_tok(1, 1'b0, b);
            set_tok(2, 1'b1, op);
        end else begin
            set_tok(0, 1'b1, op);
            set_tok(1, 1'b0, a);
            set_tok(2, 1'b0, b);
        end
        run_frame(3, m);
    endtask

    // Builds a frame in scan order, so the stack never exceeds its depth
    task automatic build_random(input int n, input pn_mode_e m);
        int   operands_left;
        int   opers_left;
        int   depth;
        int   pos;
        logic take_op;
        operands_left = (n + 1) / 2;
        opers_left    = n / 2;
        depth         = 0;
        for (int j = 0; j < n; j++) begin
            pos     = (m == MODE_POSTFIX) ? j : n - 1 - j;
            take_op = depth >= 2 && opers_left > 0 && (operands_left == 0 ||
                      depth >= `PN_STACK_DEPTH || $urandom_range(1, 0) == 1);
            if (take_op) begin
                set_tok(pos, 1'b1, 3'($urandom_range(3, 0)));
                depth--;
                opers_left--;
            end else begin
                set_tok(pos, 1'b0, 3'($urandom_range(7, 0)));
                depth++;
                operands_left--;
            end
        end
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic test_reset();
        int err_before;
        err_before = errors;
        repeat (10) begin
            @(negedge clk);
            check_valid(out_valid, 1'b0);
            check_result(out, '0);
        end
        report_test("reset_state", err_before);
    endtask

    task automatic test_postfix_ops();
        int err_before;
        err_before = errors;
        run_binary(MODE_POSTFIX, OP_ADD, 3'd5, 3'd3);
        run_binary(MODE_POSTFIX, OP_SUB, 3'd2, 3'd6);
        run_binary(MODE_POSTFIX, OP_MUL, 3'd7, 3'd6);
        run_binary(MODE_POSTFIX, OP_ABS_SUM, 3'd4, 3'd1);
        // Absolute value of a negative sum: |(2 - 7) + 1|
        set_tok(0, 1'b0, 3'd2);
        set_tok(1, 1'b0, 3'd7);
        set_tok(2, 1'b1, OP_SUB);
        set_tok(3, 1'b0, 3'd1);
        set_tok(4, 1'b1, OP_ABS_SUM);
        run_frame(5, MODE_POSTFIX);
        report_test("postfix_ops", err_before);
    endtask

    task automatic test_prefix_ops();
        int err_before;
        err_before = errors;
        run_binary(MODE_PREFIX, OP_ADD, 3'd4, 3'd3);
        run_binary(MODE_PREFIX, OP_SUB, 3'd2, 3'd5);
        run_binary(MODE_PREFIX, OP_MUL, 3'd6, 3'd7);
        run_binary(MODE_PREFIX, OP_ABS_SUM, 3'd3, 3'd1);
        report_test("prefix_ops", err_before);
    endtask

    task automatic test_single_operand();
        int err_before;
        err_before = errors;
        set_tok(0, 1'b0, 3'd6);
        run_frame(1, MODE_POSTFIX);
        set_tok(0, 1'b0, 3'd3);
        run_frame(1, MODE_PREFIX);
        report_test("single_operand", err_before);
    endtask

    task automatic test_random(input string name, input int frames);
        int       err_before;
        int       n;
        pn_mode_e m;
        err_before = errors;
        for (int f = 0; f < frames; f++) begin
            n = 2 * $urandom_range(7, 1) + 1;
            m = pn_mode_e'($urandom_range(1, 0));
            build_random(n, m);
            run_frame(n, m);
        end
        report_test(name, err_before);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        mode       = 1'b0;
        operator   = 1'b0;
        in         = '0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        valid_prev = 1'b0;
        void'($urandom(32'h3197));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_postfix_ops();
        test_prefix_ops();
        test_single_operand();
        test_random("random_nested", 30);
        // Each frame starts in the cycle right after the previous pulse
        test_random("back_to_back", 5);

        repeat (3) @(negedge clk);
        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
design/pn_pkg.sv
design/pn_token_if.sv
design/pn_stack_if.sv
design/pn_alu.sv
design/pn_operand_stack.sv
design/pn_token_buffer.sv
design/pn_evaluator.sv
design/pn_top.sv
dv/pn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module pn_tb \
    --Mdir obj_dir -o pn_sim > build.log 2>&1 &&
./obj_dir/pn_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST PASS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
